// ==== Makefile ====
# Verilator simulation of the instruction cache refill path

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= refill_tb
RTL_TOP   ?= refill_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# The log decides the result, the simulator status alone is not enough
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/refill_arbiter.sv ====
`timescale 1ns/100ps

module refill_arbiter
    import refill_axi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_fetch_i,
    input  axi_addr_t addr_fetch_i,
    input  logic      req_pref_i,
    input  axi_addr_t addr_pref_i,
    output logic      gnt_fetch_o,
    output logic      gnt_pref_o,
    output logic      rvalid_fetch_o,
    output logic      rvalid_pref_o,
    output logic      bus_req_o,
    output axi_addr_t bus_addr_o,
    input  logic      bus_gnt_i,
    input  logic      line_valid_i
);

    // High when prefetch holds priority
    logic prio_q;
    // High when the burst in flight belongs to prefetch
    logic owner_q;
    logic sel_pref;

    // --------------------------------------------------
    // Request selection
    // --------------------------------------------------
    // A lone requester wins, otherwise the pointer decides
    assign sel_pref = req_pref_i & (~req_fetch_i | prio_q);

    assign bus_req_o  = req_fetch_i | req_pref_i;
    assign bus_addr_o = sel_pref ? addr_pref_i : addr_fetch_i;

    assign gnt_fetch_o = bus_gnt_i & ~sel_pref;
    assign gnt_pref_o  = bus_gnt_i & sel_pref;

    // Old owner still valid when a new grant lands in the same cycle
    assign rvalid_fetch_o = line_valid_i & ~owner_q;
    assign rvalid_pref_o  = line_valid_i & owner_q;

    // --------------------------------------------------
    // Owner and priority
    // --------------------------------------------------
    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            prio_q  <= 1'b0;
            owner_q <= 1'b0;
        end
        else if (bus_gnt_i)
        begin
            owner_q <= sel_pref;
            // Winner drops to the back
            prio_q  <= ~sel_pref;
        end
    end

endmodule

// ==== logic/refill_axi_pkg.sv ====
package refill_axi_pkg;

    // --------------------------------------------------
    // Read channel widths
    // --------------------------------------------------
    localparam int AXI_ADDR_W     = 32;
    localparam int AXI_DATA_W     = 64;
    localparam int AXI_ID_W       = 5;
    localparam int LINE_W         = 128;
    localparam int BEATS_PER_LINE = LINE_W / AXI_DATA_W;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [1:0]            axi_resp_t;

    // Response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_EXOKAY = 2'b01;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // Incrementing burst type
    localparam logic [1:0] BURST_INCR = 2'b01;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic [3:0] cache;
        logic [2:0] prot;
        logic [3:0] qos;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

endpackage

// ==== logic/refill_bridge.sv ====
`timescale 1ns/100ps

module refill_bridge
    import refill_axi_pkg::*;
    import refill_cfg_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        req_i,
    input  axi_addr_t   addr_i,
    output logic        gnt_o,
    output logic        line_valid_o,
    output line_t       line_o,
    output logic        line_err_o,
    input  refill_cfg_t cfg_i,
    output axi_ar_t     ar_o,
    output logic        ar_valid_o,
    input  logic        ar_ready_i,
    input  axi_r_t      r_i,
    input  logic        r_valid_i,
    output logic        r_ready_o,
    output logic        refill_done_o,
    output logic        refill_err_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_BEAT0,
        WAIT_BEAT1,
        DISPATCH
    } state_e;

    state_e state_q;
    state_e state_d;

    axi_data_t [BEATS_PER_LINE-1:0] beat_q;
    logic [BEATS_PER_LINE-1:0]      beat_we;
    logic                           err_q;
    logic                           beat_err;

    // --------------------------------------------------
    // AR channel
    // --------------------------------------------------
    // Line aligned, two beats of 8 bytes
    assign ar_o.id    = cfg_i.id;
    assign ar_o.addr  = {addr_i[AXI_ADDR_W-1:4], 4'b0000};
    assign ar_o.len   = 8'd1;
    assign ar_o.size  = 3'd3;
    assign ar_o.burst = BURST_INCR;
    assign ar_o.cache = cfg_i.cache;
    assign ar_o.prot  = cfg_i.prot;
    assign ar_o.qos   = cfg_i.qos;

    // No back-pressure on R
    assign r_ready_o = 1'b1;

    assign beat_err = (r_i.resp == RESP_SLVERR) || (r_i.resp == RESP_DECERR);

    // --------------------------------------------------
    // Main FSM
    // --------------------------------------------------
    always_comb
    begin
        state_d    = state_q;
        gnt_o      = 1'b0;
        ar_valid_o = 1'b0;
        beat_we    = '0;

        case (state_q)
            // DISPATCH may issue the next burst while returning the line
            IDLE, DISPATCH:
            begin
                ar_valid_o = req_i & cfg_i.enable;
                gnt_o      = ar_valid_o & ar_ready_i;
                state_d    = gnt_o ? WAIT_BEAT0 : IDLE;
            end

            WAIT_BEAT0:
            begin
                if (r_valid_i)
                begin
                    beat_we[0] = 1'b1;
                    state_d    = r_i.last ? DISPATCH : WAIT_BEAT1;
                end
            end

            WAIT_BEAT1:
            begin
                if (r_valid_i)
                begin
                    beat_we[1] = 1'b1;
                    if (r_i.last)
                        state_d = DISPATCH;
                end
            end

            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q <= IDLE;
            err_q   <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // Sticky over one burst, cleared when the next one is issued
            if (gnt_o)
                err_q <= 1'b0;
            else if (|beat_we)
                err_q <= err_q | beat_err;
        end
    end

    // Line data
    always_ff @(posedge clk_i)
    begin
        for (int b = 0; b < BEATS_PER_LINE; b++)
        begin
            if (beat_we[b])
                beat_q[b] <= r_i.data;
        end
    end

    assign line_o        = beat_q;
    assign line_err_o    = err_q;
    assign line_valid_o  = (state_q == DISPATCH);
    assign refill_done_o = (state_q == DISPATCH);
    assign refill_err_o  = (state_q == DISPATCH) & err_q;

endmodule

// ==== logic/refill_cfg_pkg.sv ====
package refill_cfg_pkg;

    import refill_axi_pkg::*;

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam cfg_addr_t CFG_CTRL     = 2'd0;
    localparam cfg_addr_t CFG_ATTR     = 2'd1;
    localparam cfg_addr_t STAT_REFILLS = 2'd2;
    localparam cfg_addr_t STAT_ERRORS  = 2'd3;

    // Field positions
    localparam int CTRL_EN_BIT    = 0;
    localparam int ATTR_CACHE_LSB = 0;
    localparam int ATTR_PROT_LSB  = 4;
    localparam int ATTR_QOS_LSB   = 8;
    localparam int ATTR_ID_LSB    = 16;

    // Writable bits of the attribute register
    localparam cfg_data_t ATTR_MASK  = 32'h001F_0F7F;
    // Modifiable, non-bufferable by default
    localparam cfg_data_t ATTR_RESET = 32'h0000_0002;

    typedef struct packed {
        logic       enable;
        axi_id_t    id;
        logic [3:0] cache;
        logic [2:0] prot;
        logic [3:0] qos;
    } refill_cfg_t;

endpackage

// ==== logic/refill_cfg_regs.sv ====
`timescale 1ns/100ps

module refill_cfg_regs
    import refill_cfg_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        cfg_we_i,
    input  cfg_addr_t   cfg_addr_i,
    input  cfg_data_t   cfg_wdata_i,
    output cfg_data_t   cfg_rdata_o,
    input  logic        refill_done_i,
    input  logic        refill_err_i,
    output refill_cfg_t cfg_o
);

    logic      enable_q;
    cfg_data_t attr_q;
    cfg_data_t refill_cnt_q;
    cfg_data_t error_cnt_q;

    // --------------------------------------------------
    // Control and attribute registers
    // --------------------------------------------------
    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q <= 1'b0;
            attr_q   <= ATTR_RESET;
        end
        else if (cfg_we_i)
        begin
            if (cfg_addr_i == CFG_CTRL)
                enable_q <= cfg_wdata_i[CTRL_EN_BIT];
            if (cfg_addr_i == CFG_ATTR)
                attr_q <= cfg_wdata_i & ATTR_MASK;
        end
    end

    // Counters wrap; a write to the address clears it
    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            refill_cnt_q <= '0;
            error_cnt_q  <= '0;
        end
        else
        begin
            if (cfg_we_i && cfg_addr_i == STAT_REFILLS)
                refill_cnt_q <= '0;
            else if (refill_done_i)
                refill_cnt_q <= refill_cnt_q + 32'd1;

            if (cfg_we_i && cfg_addr_i == STAT_ERRORS)
                error_cnt_q <= '0;
            else if (refill_err_i)
                error_cnt_q <= error_cnt_q + 32'd1;
        end
    end

    assign cfg_o.enable = enable_q;
    assign cfg_o.id     = attr_q[ATTR_ID_LSB +: 5];
    assign cfg_o.cache  = attr_q[ATTR_CACHE_LSB +: 4];
    assign cfg_o.prot   = attr_q[ATTR_PROT_LSB +: 3];
    assign cfg_o.qos    = attr_q[ATTR_QOS_LSB +: 4];

    // Read mux
    always_comb
    begin
        case (cfg_addr_i)
            CFG_CTRL:     cfg_rdata_o = {{31{1'b0}}, enable_q};
            CFG_ATTR:     cfg_rdata_o = attr_q;
            STAT_REFILLS: cfg_rdata_o = refill_cnt_q;
            default:      cfg_rdata_o = error_cnt_q;
        endcase
    end

endmodule

// ==== logic/refill_top.sv ====
`timescale 1ns/100ps

module refill_top
    import refill_axi_pkg::*;
    import refill_cfg_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // Fetch and prefetch refill ports
    input  logic      req_0_i,
    input  axi_addr_t addr_0_i,
    output logic      gnt_0_o,
    output logic      rvalid_0_o,
    input  logic      req_1_i,
    input  axi_addr_t addr_1_i,
    output logic      gnt_1_o,
    output logic      rvalid_1_o,
    output line_t     rdata_o,
    output logic      rerr_o,

    // Configuration port
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    output cfg_data_t cfg_rdata_o,

    // AXI read master
    output axi_ar_t   ar_o,
    output logic      ar_valid_o,
    input  logic      ar_ready_i,
    input  axi_r_t    r_i,
    input  logic      r_valid_i,
    output logic      r_ready_o
);

    logic        bus_req;
    axi_addr_t   bus_addr;
    logic        bus_gnt;
    logic        line_valid;
    logic        refill_done;
    logic        refill_err;
    refill_cfg_t cfg;

    refill_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_fetch_i    (req_0_i),
        .addr_fetch_i   (addr_0_i),
        .req_pref_i     (req_1_i),
        .addr_pref_i    (addr_1_i),
        .gnt_fetch_o    (gnt_0_o),
        .gnt_pref_o     (gnt_1_o),
        .rvalid_fetch_o (rvalid_0_o),
        .rvalid_pref_o  (rvalid_1_o),
        .bus_req_o      (bus_req),
        .bus_addr_o     (bus_addr),
        .bus_gnt_i      (bus_gnt),
        .line_valid_i   (line_valid)
    );

    refill_bridge u_bridge (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (bus_req),
        .addr_i        (bus_addr),
        .gnt_o         (bus_gnt),
        .line_valid_o  (line_valid),
        .line_o        (rdata_o),
        .line_err_o    (rerr_o),
        .cfg_i         (cfg),
        .ar_o          (ar_o),
        .ar_valid_o    (ar_valid_o),
        .ar_ready_i    (ar_ready_i),
        .r_i           (r_i),
        .r_valid_i     (r_valid_i),
        .r_ready_o     (r_ready_o),
        .refill_done_o (refill_done),
        .refill_err_o  (refill_err)
    );

    refill_cfg_regs u_cfg_regs (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .refill_done_i (refill_done),
        .refill_err_i  (refill_err),
        .cfg_o         (cfg)
    );

endmodule

// ==== src.f ====
logic/refill_axi_pkg.sv
logic/refill_cfg_pkg.sv
logic/refill_cfg_regs.sv
logic/refill_arbiter.sv
logic/refill_bridge.sv
logic/refill_top.sv
verification/refill_tb.sv

// ==== verification/refill_tb.sv ====
`timescale 1ns/100ps

module refill_tb
    import refill_axi_pkg::*;
    import refill_cfg_pkg::*;
();

    localparam int          NUM_ROWS       = 16;
    localparam int          TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;
    localparam logic [31:0] SEED           = 32'hc82a;

    // Attributes programmed into CFG_ATTR
    localparam axi_id_t    ATTR_ID    = 5'h13;
    localparam logic [3:0] ATTR_CACHE = 4'hb;
    localparam logic [2:0] ATTR_PROT  = 3'h5;
    localparam logic [3:0] ATTR_QOS   = 4'h9;
    localparam cfg_data_t  ATTR_WORD  =
        {11'b0, ATTR_ID, 4'b0, ATTR_QOS, 1'b0, ATTR_PROT, ATTR_CACHE};

    typedef struct packed {
        logic [1:0] req;    // bit 0 fetch, bit 1 prefetch
        axi_addr_t  addr_f;
        axi_addr_t  addr_p;
        logic [1:0] err;    // expected rerr_o per requester
        logic       first;  // first grant when both assert
    } row_t;

    logic      clk_i;
    logic      rst_ni;
    logic      req_0_i;
    axi_addr_t addr_0_i;
    logic      gnt_0_o;
    logic      rvalid_0_o;
    logic      req_1_i;
    axi_addr_t addr_1_i;
    logic      gnt_1_o;
    logic      rvalid_1_o;
    line_t     rdata_o;
    logic      rerr_o;
    logic      cfg_we_i;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i;
    cfg_data_t cfg_rdata_o;
    axi_ar_t   ar_o;
    logic      ar_valid_o;
    logic      ar_ready_i;
    axi_r_t    r_i;
    logic      r_valid_i;
    logic      r_ready_o;

    row_t    rows [NUM_ROWS];
    axi_ar_t ar_log [$];
    axi_ar_t last_ar;
    int      errors    = 0;
    int      checks    = 0;
    int      cycle_cnt = 0;

    refill_top dut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------
    // Beat k of line a carries a + k in the upper word and ~a in the lower word
    function automatic axi_data_t beat_data(input axi_addr_t a, input logic k);
        return {a + 32'(k), ~a};
    endfunction

    function automatic line_t expected_line(input axi_addr_t a);
        return {beat_data(a, 1'b1), beat_data(a, 1'b0)};
    endfunction

    function automatic axi_ar_t expected_ar(input axi_addr_t a);
        axi_ar_t ar;
        ar.id    = ATTR_ID;
        ar.addr  = a;
        ar.len   = 8'd1;
        ar.size  = 3'd3;
        ar.burst = 2'b01;
        ar.cache = ATTR_CACHE;
        ar.prot  = ATTR_PROT;
        ar.qos   = ATTR_QOS;
        return ar;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge clk_i);
        #1;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b0;
    endtask

    task automatic check_reg(input cfg_addr_t addr, input cfg_data_t exp, input string name);
        @(posedge clk_i);
        #1;
        cfg_addr_i = addr;
        @(negedge clk_i);
        check_value(name, 128'(cfg_rdata_o), 128'(exp));
    endtask

    task automatic drive_requests(input row_t row);
        @(posedge clk_i);
        #1;
        req_0_i  = row.req[0];
        addr_0_i = row.addr_f;
        req_1_i  = row.req[1];
        addr_1_i = row.addr_p;
    endtask

    // Watches grants and returned lines until every request of the row is answered
    task automatic collect_row(input row_t row);
        logic [1:0] gnt;
        logic [1:0] rv;
        logic [1:0] granted;
        logic [1:0] answered;
        logic [1:0] drop;
        int         order [2];
        int         n_gnt;
        int         n_resp;
        int         n;
        axi_addr_t  a;
        axi_ar_t    ar;
        granted  = 2'b00;
        answered = 2'b00;
        n_gnt    = 0;
        n_resp   = 0;
        order[0] = 0;
        order[1] = 0;
        while (n_resp < $countones(row.req))
        begin
            @(negedge clk_i);
            gnt  = {gnt_1_o, gnt_0_o};
            rv   = {rvalid_1_o, rvalid_0_o};
            drop = 2'b00;
            if (gnt == 2'b11)
                report_problem("Both requesters were granted in the same cycle");
            for (n = 0; n < 2; n++)
            begin
                if (gnt[n] && (!row.req[n] || granted[n]))
                    report_problem($sformatf("Requester %0d granted with no pending request", n));
                else if (gnt[n])
                begin
                    granted[n]   = 1'b1;
                    order[n_gnt] = n;
                    n_gnt++;
                    drop[n]      = 1'b1;
                end
            end
            for (n = 0; n < 2; n++)
            begin
                if (rv[n] && (!granted[n] || answered[n]))
                    report_problem($sformatf("Requester %0d got a line it never asked for", n));
                else if (rv[n])
                begin
                    if (order[n_resp] != n)
                        report_problem("A line came back out of grant order");
                    a = (n == 1) ? row.addr_p : row.addr_f;
                    a = {a[31:4], 4'h0};
                    check_value("rdata_o", rdata_o, expected_line(a));
                    check_value("rerr_o", 128'(rerr_o), 128'(row.err[n]));
                    if (ar_log.size() == 0)
                        report_problem("A line came back with no AR accepted for it");
                    else
                    begin
                        ar = ar_log.pop_front();
                        check_value("ar_o", 128'(ar), 128'(expected_ar(a)));
                    end
                    answered[n] = 1'b1;
                    n_resp++;
                end
            end
            @(posedge clk_i);
            #1;
            if (drop[0])
                req_0_i = 1'b0;
            if (drop[1])
                req_1_i = 1'b0;
        end
        if (row.req == 2'b11)
            check_value("first grant", 128'(order[0]), 128'(row.first));
    endtask

    task automatic load_rows();
        rows[0]  = '{2'b11, 32'h0000_1004, 32'h0020_204c, 2'b00, 1'b0};
        rows[1]  = '{2'b01, 32'h0001_0008, 32'h0000_0000, 2'b00, 1'b0};
        rows[2]  = '{2'b11, 32'h0010_0000, 32'h0000_3000, 2'b01, 1'b1};
        rows[3]  = '{2'b10, 32'h0000_0000, 32'h0030_0010, 2'b10, 1'b1};
        rows[4]  = '{2'b11, 32'h8a2f_0ff0, 32'h4c3e_7718, 2'b10, 1'b0};
        rows[5]  = '{2'b11, 32'h0050_0100, 32'h0051_0200, 2'b11, 1'b0};
        rows[6]  = '{2'b01, 32'h1234_5678, 32'h0000_0000, 2'b01, 1'b0};
        rows[7]  = '{2'b11, 32'h0000_00f0, 32'h00ff_fff0, 2'b10, 1'b1};
        rows[8]  = '{2'b10, 32'h0000_0000, 32'habc0_0020, 2'b00, 1'b1};
        rows[9]  = '{2'b01, 32'h7770_1230, 32'h0000_0000, 2'b01, 1'b0};
        rows[10] = '{2'b01, 32'h0002_0040, 32'h0000_0000, 2'b00, 1'b0};
        rows[11] = '{2'b11, 32'h0100_0080, 32'h0110_00c0, 2'b10, 1'b1};
        rows[12] = '{2'b11, 32'h0f1e_2d3c, 32'h0e2d_3c4b, 2'b01, 1'b1};
        rows[13] = '{2'b10, 32'h0000_0000, 32'hfff0_fff8, 2'b10, 1'b1};
        rows[14] = '{2'b11, 32'h3c4d_5e60, 32'h2468_ace0, 2'b00, 1'b0};
        rows[15] = '{2'b01, 32'h1357_9bdf, 32'h0000_0000, 2'b01, 1'b0};
    endtask

    // --------------------------------------------------
    // AXI read slave
    // --------------------------------------------------
    // SLVERR on the second beat when address bit 20 is set
    initial
    begin : axi_slave
        int delay;
        int gap;
        int k;
        ar_ready_i = 1'b0;
        r_valid_i  = 1'b0;
        r_i        = '0;
        last_ar    = '0;
        wait (rst_ni === 1'b1);
        forever
        begin
            @(negedge clk_i);
            if (ar_valid_o)
            begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                #1;
                ar_ready_i = 1'b1;
                @(negedge clk_i);
                last_ar = ar_o;
                ar_log.push_back(ar_o);
                @(posedge clk_i);
                #1;
                ar_ready_i = 1'b0;
                for (k = 0; k < BEATS_PER_LINE; k++)
                begin
                    gap = $urandom_range(2, 0);
                    repeat (gap)
                    begin
                        @(posedge clk_i);
                        #1;
                    end
                    r_valid_i = 1'b1;
                    r_i.id    = last_ar.id;
                    r_i.data  = beat_data(last_ar.addr, k[0]);
                    r_i.resp  = (k == 1 && last_ar.addr[20]) ? RESP_SLVERR : RESP_OKAY;
                    r_i.last  = (k == BEATS_PER_LINE - 1);
                    // Every beat must be taken in the cycle it is offered
                    @(negedge clk_i);
                    check_value("r_ready_o", 128'(r_ready_o), 128'(1'b1));
                    @(posedge clk_i);
                    #1;
                    r_valid_i = 1'b0;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk_i)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin : main_seq
        int exp_refills;
        int exp_errors;
        int r;
        void'($urandom(SEED));
        rst_ni      = 1'b0;
        req_0_i     = 1'b0;
        addr_0_i    = '0;
        req_1_i     = 1'b0;
        addr_1_i    = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = CFG_CTRL;
        cfg_wdata_i = '0;
        exp_refills = 0;
        exp_errors  = 0;
        load_rows();
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        check_reg(CFG_CTRL, 32'h0, "cfg_rdata_o (CFG_CTRL)");
        check_reg(CFG_ATTR, 32'h2, "cfg_rdata_o (CFG_ATTR)");
        check_reg(STAT_REFILLS, 32'h0, "cfg_rdata_o (STAT_REFILLS)");

        // Requests stay pending while the bridge is disabled
        drive_requests(rows[0]);
        write_reg(CFG_ATTR, ATTR_WORD);
        repeat (20)
        begin
            @(negedge clk_i);
            if (gnt_0_o || gnt_1_o || ar_valid_o)
                report_problem("Grant or AR valid seen while the bridge is disabled");
        end
        check_reg(CFG_ATTR, ATTR_WORD, "cfg_rdata_o (CFG_ATTR)");
        write_reg(CFG_CTRL, 32'h1);

        for (r = 0; r < NUM_ROWS; r++)
        begin
            if (r > 0)
                drive_requests(rows[r]);
            collect_row(rows[r]);
            exp_refills += $countones(rows[r].req);
            exp_errors  += $countones(rows[r].req & rows[r].err);
        end
        if (ar_log.size() != 0)
            report_problem("An AR was accepted but its line never came back");

        check_reg(STAT_REFILLS, exp_refills, "cfg_rdata_o (STAT_REFILLS)");
        check_reg(STAT_ERRORS, exp_errors, "cfg_rdata_o (STAT_ERRORS)");
        write_reg(STAT_REFILLS, 32'h0);
        write_reg(STAT_ERRORS, 32'h0);
        check_reg(STAT_REFILLS, 32'h0, "cfg_rdata_o (STAT_REFILLS)");
        check_reg(STAT_ERRORS, 32'h0, "cfg_rdata_o (STAT_ERRORS)");

        $display("Run complete, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
